// ==== source/vga_pkg.sv ====
// Shared types for the VGA controller and its testbench
package vga_pkg;
	// Register byte offsets from the block base address
	localparam logic [31:0] reg_offset_enable = 32'd0;
	localparam logic [31:0] reg_offset_program = 32'd4;
	localparam logic [31:0] reg_offset_base = 32'd8;
	localparam logic [31:0] reg_offset_length = 32'd12;

	// AXI4 read address channel, master to slave
	typedef struct packed {
		logic valid;
		logic [31:0] addr;
		logic [7:0] len;
	} axi_ar_t;

	// AXI4 read data channel, slave to master
	typedef struct packed {
		logic valid;
		logic [31:0] data;
		logic last;
	} axi_r_t;

	// Framebuffer DMA states
	typedef enum logic [1:0] {
		wait_frame_start,
		wait_fifo_space,
		issue_addr,
		burst_active
	} dma_state_t;

	// Timing program opcodes
	typedef enum logic [1:0] {
		op_emit = 2'd0,
		op_loop = 2'd1,
		op_restart = 2'd2
	} seq_opcode_t;

	// One timing program word, as written through the program port
	typedef struct packed {
		seq_opcode_t opcode;
		logic hsync;
		logic vsync;
		logic visible;
		logic frame_start;
		logic [4:0] target;
		logic [15:0] count;
		logic [4:0] unused;
	} seq_instr_t;
endpackage

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

// Circular buffer FIFO with show-ahead output
module sync_fifo
	#(parameter WIDTH = 32,
	parameter DEPTH = 128,
	parameter ALMOST_EMPTY_THRESHOLD = 63)
	(input clk,
	input reset,
	input flush,
	input push,
	input [WIDTH-1:0] push_data,
	input pop,
	output logic [WIDTH-1:0] pop_data,
	output logic empty,
	output logic full,
	output logic almost_empty);

	localparam ADDR_WIDTH = $clog2(DEPTH);
	localparam COUNT_WIDTH = $clog2(DEPTH + 1);
	localparam logic [ADDR_WIDTH-1:0] LAST_SLOT = ADDR_WIDTH'(DEPTH - 1);

	logic [WIDTH-1:0] storage[DEPTH];
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] head_index;
	logic [COUNT_WIDTH-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = count == '0;
	assign full = count == COUNT_WIDTH'(DEPTH);
	assign almost_empty = count <= COUNT_WIDTH'(ALMOST_EMPTY_THRESHOLD);

	// Drop pushes into a full buffer unless a pop frees a slot
	assign do_push = push && (!full || pop);
	assign do_pop = pop && !empty;

	// When empty, keep presenting the word that was read last
	assign head_index = !empty ? rd_ptr : (rd_ptr == '0 ? LAST_SLOT : rd_ptr - 1'b1);
	assign pop_data = storage[head_index];

	always_ff @(posedge clk)
	begin
		if (do_push)
			storage[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			// Drop everything in one cycle
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr == LAST_SLOT ? '0 : wr_ptr + 1'b1;

			if (do_pop)
				rd_ptr <= rd_ptr == LAST_SLOT ? '0 : rd_ptr + 1'b1;

			// Occupancy only moves when exactly one side is active
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end
endmodule

// ==== source/vga_sequencer.sv ====
`timescale 1ns/1ps

// Programmable video timing generator
module vga_sequencer
	import vga_pkg::*;
	#(parameter PROGRAM_DEPTH = 32)
	(input clk,
	input reset,
	input enable,
	input prog_write_en,
	input prog_restart,
	input seq_instr_t prog_data,
	output logic pixel_en,
	output logic hsync,
	output logic vsync,
	output logic in_visible_region,
	output logic frame_start);

	localparam PC_WIDTH = $clog2(PROGRAM_DEPTH);

	seq_instr_t program_mem[PROGRAM_DEPTH];
	logic [PC_WIDTH-1:0] write_ptr;
	logic [PC_WIDTH-1:0] pc;
	seq_instr_t fetch;
	logic [15:0] repeat_count;
	logic [15:0] loop_count;
	logic [15:0] loop_remaining;
	logic loop_active;
	logic emit_done;

	// Slot after the given one, wrapping at the end of the program
	function automatic logic [PC_WIDTH-1:0] next_slot(input logic [PC_WIDTH-1:0] slot);
		return slot == PC_WIDTH'(PROGRAM_DEPTH - 1) ? '0 : slot + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (prog_write_en)
			program_mem[write_ptr] <= prog_data;
	end

	// Program port pointer, rewound by a restart strobe
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			write_ptr <= '0;
		else if (prog_restart)
			write_ptr <= '0;
		else if (prog_write_en)
			write_ptr <= next_slot(write_ptr);
	end

	// Pixel rate is half the system clock, free running
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			pixel_en <= 1'b0;
		else
			pixel_en <= !pixel_en;
	end

	// pc points at the next instruction, not the one being output
	assign fetch = program_mem[pc];
	assign emit_done = pixel_en && repeat_count == '0;
	assign loop_remaining = loop_active ? loop_count : fetch.count;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset || !enable)
		begin
			pc <= '0;
			repeat_count <= '0;
			loop_count <= '0;
			loop_active <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			in_visible_region <= 1'b0;
			frame_start <= 1'b0;
		end
		else
		begin
			frame_start <= 1'b0;
			if (pixel_en && repeat_count != '0)
				repeat_count <= repeat_count - 1'b1;

			if (fetch.opcode == op_emit)
			begin
				// Swap in the next levels on the last pixel of the current emit
				if (emit_done)
				begin
					hsync <= fetch.hsync;
					vsync <= fetch.vsync;
					in_visible_region <= fetch.visible;
					frame_start <= fetch.frame_start;
					repeat_count <= fetch.count;
					pc <= next_slot(pc);
				end
			end
			else
			begin
				// Control steps resolve in the background while an emit runs
				case (fetch.opcode)
					op_loop:
					begin
						// Branch count times, so the body runs count+1 times
						if (loop_remaining != '0)
						begin
							pc <= PC_WIDTH'(fetch.target);
							loop_count <= loop_remaining - 1'b1;
							loop_active <= 1'b1;
						end
						else
						begin
							pc <= next_slot(pc);
							loop_active <= 1'b0;
						end
					end

					// op_restart, and undefined opcodes go back to the top
					default:
					begin
						pc <= '0;
						loop_active <= 1'b0;
					end
				endcase
			end
		end
	end
endmodule

// ==== source/vga_dma.sv ====
`timescale 1ns/1ps

// Frame DMA, reads the framebuffer as fixed length AXI bursts
module vga_dma
	import vga_pkg::*;
	#(parameter BURST_LENGTH = 64)
	(input clk,
	input reset,
	input enable,
	input frame_start,
	input [31:0] fb_base,
	input [31:0] fb_length,
	input fifo_almost_empty,
	input arready,
	input axi_r_t r,
	output axi_ar_t ar,
	output logic rready);

	localparam logic [7:0] BEAT_LAST = 8'(BURST_LENGTH - 1);
	localparam logic [31:0] BURST_BYTES = 32'(BURST_LENGTH * 4);

	dma_state_t state;
	logic [7:0] beat_count;
	logic [31:0] pixel_count;
	logic [31:0] burst_addr;
	logic frame_done;

	// Current burst holds the last pixels of the frame
	assign frame_done = pixel_count + 32'(BURST_LENGTH) >= fb_length;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= wait_frame_start;
			beat_count <= '0;
			pixel_count <= '0;
			burst_addr <= '0;
		end
		else
		begin
			unique case (state)
				// The FIFO is flushed on the same pulse, so each frame starts clean
				wait_frame_start:
				begin
					if (frame_start && enable && fb_length != '0)
					begin
						state <= issue_addr;
						beat_count <= '0;
						pixel_count <= '0;
						burst_addr <= fb_base;
					end
				end

				// Hold off until a whole burst fits
				wait_fifo_space:
				begin
					if (!enable)
						state <= wait_frame_start;
					else if (fifo_almost_empty)
						state <= issue_addr;
				end

				// Address held until the slave takes it
				issue_addr:
				begin
					if (arready)
						state <= burst_active;
				end

				burst_active:
				begin
					if (r.valid)
					begin
						if (beat_count == BEAT_LAST)
						begin
							beat_count <= '0;
							burst_addr <= burst_addr + BURST_BYTES;
							pixel_count <= pixel_count + 32'(BURST_LENGTH);
							if (frame_done || !enable)
								state <= wait_frame_start;
							else if (fifo_almost_empty)
								state <= issue_addr;
							else
								state <= wait_fifo_space;
						end
						else
							beat_count <= beat_count + 1'b1;
					end
				end
			endcase
		end
	end

	assign ar = '{valid: state == issue_addr, addr: burst_addr, len: BEAT_LAST};

	// Room for the whole burst was checked before the request went out
	assign rready = 1'b1;
endmodule

// ==== source/vga_controller.sv ====
`timescale 1ns/1ps

// VGA display controller, framebuffer fetched over AXI and sent to a video DAC
module vga_controller
	import vga_pkg::*;
	#(parameter logic [31:0] BASE_ADDRESS = 32'h0,
	parameter BURST_LENGTH = 64,
	parameter FIFO_DEPTH = 128,
	parameter PROGRAM_DEPTH = 32)
	(input clk,
	input reset,
	input [31:0] io_address,
	input [31:0] io_write_data,
	input io_write_en,
	input arready,
	input axi_r_t r,
	output axi_ar_t ar,
	output logic rready,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_clk,
	output logic vga_blank_n,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_sync_n);

	localparam logic [31:0] DEFAULT_FB_BASE = 32'h200000;

	logic enable;
	logic [31:0] fb_base;
	logic [31:0] fb_length;
	logic write_enable_reg;
	logic prog_write_en;
	logic prog_restart;
	logic pixel_en;
	logic in_visible_region;
	logic frame_start;
	logic fifo_empty;
	logic fifo_almost_empty;
	logic [31:0] fifo_data;

	// Register strobe decode
	assign write_enable_reg = io_write_en && io_address == BASE_ADDRESS + reg_offset_enable;
	assign prog_write_en = io_write_en && io_address == BASE_ADDRESS + reg_offset_program;
	// Bit 1 of an enable write rewinds the program port
	assign prog_restart = write_enable_reg && io_write_data[1];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			enable <= 1'b0;
			fb_base <= DEFAULT_FB_BASE;
			fb_length <= '0;
		end
		else if (io_write_en)
		begin
			if (write_enable_reg)
				enable <= io_write_data[0];

			if (io_address == BASE_ADDRESS + reg_offset_base)
				fb_base <= io_write_data;

			if (io_address == BASE_ADDRESS + reg_offset_length)
				fb_length <= io_write_data;
		end
	end

	// Threshold leaves space for one full burst plus a slot
	sync_fifo #(
		.WIDTH(32),
		.DEPTH(FIFO_DEPTH),
		.ALMOST_EMPTY_THRESHOLD(FIFO_DEPTH - BURST_LENGTH - 1)) pixel_fifo(
		.clk(clk),
		.reset(reset),
		.flush(frame_start),
		.push(r.valid),
		.push_data(r.data),
		.pop(pixel_en && in_visible_region && !fifo_empty),
		.pop_data(fifo_data),
		.empty(fifo_empty),
		.full(),
		.almost_empty(fifo_almost_empty));

	vga_sequencer #(.PROGRAM_DEPTH(PROGRAM_DEPTH)) sequencer(
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.prog_write_en(prog_write_en),
		.prog_restart(prog_restart),
		.prog_data(seq_instr_t'(io_write_data)),
		.pixel_en(pixel_en),
		.hsync(vga_hs),
		.vsync(vga_vs),
		.in_visible_region(in_visible_region),
		.frame_start(frame_start));

	vga_dma #(.BURST_LENGTH(BURST_LENGTH)) dma(
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.frame_start(frame_start),
		.fb_base(fb_base),
		.fb_length(fb_length),
		.fifo_almost_empty(fifo_almost_empty),
		.arready(arready),
		.r(r),
		.ar(ar),
		.rready(rready));

	// Pixel word is RGBA, alpha byte not sent
	assign vga_r = fifo_data[31:24];
	assign vga_g = fifo_data[23:16];
	assign vga_b = fifo_data[15:8];

	// DAC samples on the pixel enable itself
	assign vga_clk = pixel_en;
	assign vga_blank_n = in_visible_region;
	// Sync on green not used
	assign vga_sync_n = 1'b0;
endmodule

// ==== bench/axi_read_memory.sv ====
`timescale 1ns/1ps

// Behavioral AXI4 read slave, serves a fixed address-derived pattern
module axi_read_memory
	import vga_pkg::*;
	#(parameter logic [31:0] PATTERN_KEY = 32'hA5A5A5A5)
	(input clk,
	input reset,
	input axi_ar_t ar,
	output logic arready,
	output axi_r_t r);

	logic [31:0] burst_addr;
	logic [7:0] burst_len;
	int beat;

	initial
	begin
		// One seed for the whole run
		void'($urandom(32'h618e));
		arready = 1'b0;
		r = '0;
		forever
		begin
			@(negedge clk);
			if (!reset && ar.valid)
			begin
				// Random latency before taking the address
				repeat ($urandom_range(3)) @(negedge clk);
				burst_addr = ar.addr;
				burst_len = ar.len;
				arready = 1'b1;
				@(negedge clk);
				arready = 1'b0;
				for (beat = 0; beat <= int'(burst_len); beat++)
				begin
					// Gap of 0 to 3 cycles before each beat
					repeat ($urandom_range(3)) @(negedge clk);
					r = '{valid: 1'b1,
						data: (burst_addr + 32'(beat * 4)) ^ PATTERN_KEY,
						last: beat == int'(burst_len)};
					@(negedge clk);
					r = '0;
				end
			end
		end
	end
endmodule

// ==== bench/vga_controller_tb.sv ====
`timescale 1ns/1ps

// Testbench for the VGA controller with a small 16x4 frame
module vga_controller_tb;
	import vga_pkg::*;

	localparam logic [31:0] PATTERN_KEY = 32'hA5A5A5A5;
	localparam int FRAME_CLOCKS = 250;
	localparam int TEST_FRAMES = 12;
	localparam realtime FRAME_NS = FRAME_CLOCKS * 100.0;

	logic clk;
	logic reset;
	logic [31:0] io_address;
	logic [31:0] io_write_data;
	logic io_write_en;
	logic arready;
	axi_r_t r;
	axi_ar_t ar;
	logic rready;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic vga_clk;
	logic vga_blank_n;
	logic vga_hs;
	logic vga_vs;
	logic vga_sync_n;

	// Scoreboard state
	int error_count = 0;
	logic [31:0] cur_base;
	logic [31:0] frame_base;
	logic video_on = 1'b0;
	logic checking = 1'b0;
	logic frame_full = 1'b0;
	logic vs_prev = 1'b0;
	int frames = 0;
	int burst_idx = 0;
	int ar_total = 0;
	int ar_at_disable;
	int pix_idx = 0;
	int hs_run = 0;
	int hs_pulses = 0;
	int vs_run = 0;
	logic [31:0] expected_word;

	vga_controller #(
		.BASE_ADDRESS(32'h0),
		.BURST_LENGTH(16),
		.FIFO_DEPTH(32)) dut(.*);

	axi_read_memory #(.PATTERN_KEY(PATTERN_KEY)) memory(
		.clk(clk),
		.reset(reset),
		.ar(ar),
		.arready(arready),
		.r(r));

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = !clk;
	end

	// Report a wrong value and stop
	task automatic check_fail(input string msg);
		error_count++;
		$display("FAILED at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "first error reached");
	endtask

	// One register write on the strobe driven on the falling edge
	task automatic reg_write(input logic [31:0] offset, input logic [31:0] data);
		@(negedge clk);
		io_address = offset;
		io_write_data = data;
		io_write_en = 1'b1;
		@(negedge clk);
		io_write_en = 1'b0;
	endtask

	// Packs one timing instruction
	function automatic logic [31:0] make_instr(input seq_opcode_t op, input logic hs,
		input logic vs, input logic vis, input logic fs, input logic [4:0] target,
		input logic [15:0] count);
		seq_instr_t instr;
		instr = '{opcode: op, hsync: hs, vsync: vs, visible: vis, frame_start: fs,
			target: target, count: count, unused: 5'd0};
		return instr;
	endfunction

	// AR acceptance sampled on the edge that completes the handshake
	always @(posedge clk)
	begin
		if (!reset && ar.valid && arready)
		begin
			ar_total++;
			assert (ar.len == 8'd15)
			else check_fail($sformatf("AR len %0d, expected 15", ar.len));
			assert (ar.addr == frame_base + 32'(64 * burst_idx))
			else check_fail($sformatf("AR addr %h, expected %h", ar.addr,
				frame_base + 32'(64 * burst_idx)));
			assert (burst_idx < 4)
			else check_fail("more than four bursts in one frame");
			burst_idx++;
		end
	end

	// Pixel side monitor sampled at the falling edge where outputs are stable
	always @(negedge clk)
	begin
		if (!reset)
		begin
			assert (vga_sync_n == 1'b0)
			else check_fail("vga_sync_n is not held low");
			assert (rready == 1'b1)
			else check_fail("rready is not held high");
			if (vga_clk)
			begin
				// Rising vsync marks the frame start
				if (vga_vs && !vs_prev)
				begin
					if (frame_full)
					begin
						assert (burst_idx == 4)
						else check_fail($sformatf("%0d bursts in frame", burst_idx));
						assert (pix_idx == 64)
						else check_fail($sformatf("%0d visible pixels in frame", pix_idx));
						assert (hs_pulses == 5)
						else check_fail($sformatf("%0d hsync pulses in frame", hs_pulses));
					end
					frames++;
					burst_idx = 0;
					pix_idx = 0;
					hs_pulses = 0;
					frame_base = cur_base;
					checking = video_on;
					frame_full = video_on;
				end
				vs_prev = vga_vs;
				if (checking)
				begin
					if (vga_blank_n)
					begin
						expected_word = (frame_base + 32'(pix_idx * 4)) ^ PATTERN_KEY;
						assert (pix_idx < 64 && {vga_r, vga_g, vga_b} == expected_word[31:8])
						else check_fail($sformatf("pixel %0d is %h, expected %h", pix_idx,
							{vga_r, vga_g, vga_b}, expected_word[31:8]));
						pix_idx++;
					end
					// Sync widths, counted in pixels
					if (vga_hs)
						hs_run++;
					else if (hs_run != 0)
					begin
						assert (hs_run == 3)
						else check_fail($sformatf("hsync lasted %0d pixels", hs_run));
						hs_run = 0;
						hs_pulses++;
					end
					if (vga_vs)
						vs_run++;
					else if (vs_run != 0)
					begin
						assert (vs_run == 25)
						else check_fail($sformatf("vsync lasted %0d pixels", vs_run));
						vs_run = 0;
					end
				end
			end
		end
	end

	initial
	begin
		#(FRAME_NS * (TEST_FRAMES + 5));
		$display("Watchdog expired before the test finished");
		$display("Test failed");
		$fatal(1, "timeout");
	end

	initial
	begin
		reset = 1'b1;
		io_address = '0;
		io_write_data = '0;
		io_write_en = 1'b0;
		cur_base = 32'h1000;
		frame_base = 32'h1000;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// Idle outputs before the block is enabled
		repeat (8)
		begin
			@(negedge clk);
			assert (!ar.valid && !vga_blank_n && !vga_hs && !vga_vs && !vga_sync_n)
			else check_fail("outputs not idle after reset");
		end

		// Four visible lines then one vblank line, 25 pixels each
		reg_write(reg_offset_program, make_instr(op_emit, 0, 0, 1, 0, 0, 15));
		reg_write(reg_offset_program, make_instr(op_emit, 0, 0, 0, 0, 0, 3));
		reg_write(reg_offset_program, make_instr(op_emit, 1, 0, 0, 0, 0, 2));
		reg_write(reg_offset_program, make_instr(op_emit, 0, 0, 0, 0, 0, 1));
		reg_write(reg_offset_program, make_instr(op_loop, 0, 0, 0, 0, 0, 3));
		reg_write(reg_offset_program, make_instr(op_emit, 0, 1, 0, 1, 0, 15));
		reg_write(reg_offset_program, make_instr(op_emit, 0, 1, 0, 0, 0, 3));
		reg_write(reg_offset_program, make_instr(op_emit, 1, 1, 0, 0, 0, 2));
		reg_write(reg_offset_program, make_instr(op_emit, 0, 1, 0, 0, 0, 1));
		reg_write(reg_offset_program, make_instr(op_restart, 0, 0, 0, 0, 0, 0));
		reg_write(reg_offset_base, cur_base);
		reg_write(reg_offset_length, 32'd64);
		video_on = 1'b1;
		reg_write(reg_offset_enable, 32'd1);

		// Three whole frames until the fourth start closes the last one
		wait (frames >= 4);

		// Abort in the visible part of a frame, after two bursts
		wait (frames >= 5 && burst_idx >= 2);
		@(negedge clk);
		while (!vga_blank_n)
			@(negedge clk);
		video_on = 1'b0;
		checking = 1'b0;
		frame_full = 1'b0;
		hs_run = 0;
		vs_run = 0;
		ar_at_disable = ar_total;
		reg_write(reg_offset_enable, 32'd0);
		repeat (2 * FRAME_CLOCKS) @(negedge clk);
		assert (ar_total - ar_at_disable <= 1)
		else check_fail($sformatf("%0d AR after disable", ar_total - ar_at_disable));

		// Restart from a new framebuffer
		cur_base = 32'h8000;
		reg_write(reg_offset_base, cur_base);
		video_on = 1'b1;
		reg_write(reg_offset_enable, 32'd1);
		wait (frames >= 9);

		if (error_count == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("Test failed");
			$fatal(1, "errors found");
		end
	end
endmodule

// ==== src.f ====
source/vga_pkg.sv
source/sync_fifo.sv
source/vga_sequencer.sv
source/vga_dma.sv
source/vga_controller.sv
bench/axi_read_memory.sv
bench/vga_controller_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0
TOP ?= vga_controller_tb
FILELIST ?= src.f
LOG ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
